// File: verilog.f
pulsesync_pkg.sv
axil_write_channel.sv
axil_read_channel.sv
pulsesync_reg_file.sv
pulsesync_memory_map.sv
pulsesync_memory_map_props.sv
tb_pulsesync_memory_map.sv

// File: Bender.yml
package:
  name: pulsesync_memory_map

sources:
  - pulsesync_pkg.sv
  - axil_write_channel.sv
  - axil_read_channel.sv
  - pulsesync_reg_file.sv
  - pulsesync_memory_map.sv
  - target: simulation
    files:
      - pulsesync_memory_map_props.sv
      - tb_pulsesync_memory_map.sv

// File: tb_pulsesync_memory_map.sv
`timescale 1ns/1ps

module tb_pulsesync_memory_map
    import pulsesync_pkg::*;
();

    localparam int ADDR_WIDTH  = 8;
    // 200 transactions of at most 40 cycles plus the reset stretch
    localparam int CYCLE_LIMIT = 200 * 40 + 16;

    logic                  clk;
    logic                  rst_n;
    logic [ADDR_WIDTH-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    data_word_t            wdata;
    byte_strobe_t          wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [ADDR_WIDTH-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    data_word_t            rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;
    data_word_t            pulsesync_status;
    data_word_t            gen_status;
    data_word_t            pwm_status;
    data_word_t            pulsesync_ctrl;
    data_word_t            pwm_ctrl;
    data_word_t            pwm_val;
    data_word_t            gen_ctrl;

    // Reference model state
    data_word_t pwm_val_model;
    data_word_t ps_status_model;
    data_word_t gen_status_model;
    data_word_t pwm_status_model;

    integer seed;
    int     errors;
    int     tests;
    int     failed_tests;
    int     test_start_errors;
    int     cycles;

    pulsesync_memory_map #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_pulsesync_memory_map (
        .s_axi_aclk      (clk),
        .s_axi_aresetn   (rst_n),
        .s_axi_awaddr    (awaddr),
        .s_axi_awvalid   (awvalid),
        .s_axi_awready   (awready),
        .s_axi_wdata     (wdata),
        .s_axi_wstrb     (wstrb),
        .s_axi_wvalid    (wvalid),
        .s_axi_wready    (wready),
        .s_axi_bresp     (bresp),
        .s_axi_bvalid    (bvalid),
        .s_axi_bready    (bready),
        .s_axi_araddr    (araddr),
        .s_axi_arvalid   (arvalid),
        .s_axi_arready   (arready),
        .s_axi_rdata     (rdata),
        .s_axi_rresp     (rresp),
        .s_axi_rvalid    (rvalid),
        .s_axi_rready    (rready),
        .pulsesync_status(pulsesync_status),
        .gen_status      (gen_status),
        .pwm_status      (pwm_status),
        .pulsesync_ctrl  (pulsesync_ctrl),
        .pwm_ctrl        (pwm_ctrl),
        .pwm_val         (pwm_val),
        .gen_ctrl        (gen_ctrl)
    );

    bind pulsesync_memory_map pulsesync_memory_map_props u_props (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog on the total run length
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ------------------------------
    // Model and check helpers
    // ------------------------------

    // Strobed bytes come from data and the rest from base
    function automatic data_word_t apply_strobe(input data_word_t base, input data_word_t data,
                                                input byte_strobe_t strb);
        data_word_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (base & ~mask) | (data & mask);
    endfunction

    // Expected readback per index with control words reading as zero
    function automatic data_word_t expected_read(input reg_index_t idx);
        case (idx)
            IDX_PULSESYNC_STATUS: return ps_status_model;
            IDX_GEN_STATUS:       return gen_status_model;
            IDX_PWM_STATUS:       return pwm_status_model;
            IDX_VERSION:          return VERSION_WORD;
            IDX_VALIDATION:       return VALIDATION_WORD;
            default:              return '0;
        endcase
    endfunction

    // Random bits around the word index that the DUT ignores
    function automatic logic [ADDR_WIDTH-1:0] make_addr(input reg_index_t idx);
        logic [ADDR_WIDTH-1:0] addr;
        addr = ADDR_WIDTH'($random(seed));
        addr[ADDR_LSB +: $bits(reg_index_t)] = idx;
        return addr;
    endfunction

    // Failed checks so far in both the testbench and the bound assertions
    function automatic int error_total();
        return errors + u_pulsesync_memory_map.u_props.failures;
    endfunction

    task automatic check_word(input string name, input data_word_t expected,
                              input data_word_t actual);
        assert (actual === expected)
        else begin
            $display("** Error: %s expected %h, got %h at %0t", name, expected, actual, $time);
            errors++;
        end
    endtask

    task automatic check_controls(input data_word_t ps, input data_word_t pc,
                                  input data_word_t gc);
        check_word("pulsesync_ctrl", ps, pulsesync_ctrl);
        check_word("pwm_ctrl", pc, pwm_ctrl);
        check_word("gen_ctrl", gc, gen_ctrl);
        check_word("pwm_val", pwm_val_model, pwm_val);
    endtask

    task automatic begin_test();
        tests++;
        test_start_errors = error_total();
    endtask

    task automatic end_test(input string name);
        // Assertions of the last rising edge have reported by now
        @(negedge clk);
        if (error_total() > test_start_errors) begin
            failed_tests++;
            $display("test %-16s fail, %0d errors", name, error_total() - test_start_errors);
        end else begin
            $display("test %-16s pass", name);
        end
    endtask

    // ------------------------------
    // AXI4-Lite transactions
    // ------------------------------

    // One write with bready low for stall+1 cycles and an optional second write pending
    task automatic write_word(input reg_index_t idx, input data_word_t data,
                              input byte_strobe_t strb, input int stall, input bit probe);
        data_word_t pulse;
        data_word_t exp_ps;
        data_word_t exp_pc;
        data_word_t exp_gc;
        int         i;
        pulse  = apply_strobe('0, data, strb);
        exp_ps = (idx == IDX_PULSESYNC_CTRL) ? pulse : '0;
        exp_pc = (idx == IDX_PWM_CTRL) ? pulse : '0;
        exp_gc = (idx == IDX_GEN_CTRL) ? pulse : '0;
        if (idx == IDX_PWM_VAL) begin
            pwm_val_model = apply_strobe(pwm_val_model, data, strb);
        end
        @(posedge clk);
        awaddr  <= make_addr(idx);
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(negedge clk); while (!awready);
        check_word("wready", 1, wready);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        // Pulse lines up with the first bvalid cycle
        @(negedge clk);
        check_word("bvalid", 1, bvalid);
        check_word("bresp", RESP_OKAY, bresp);
        check_controls(exp_ps, exp_pc, exp_gc);
        if (probe) begin
            // Unmapped write offered while the response is pending
            @(posedge clk);
            awaddr  <= make_addr(4'hf);
            wdata   <= $random(seed);
            wstrb   <= 4'hf;
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
        end
        for (i = 0; i <= stall; i++) begin
            @(negedge clk);
            check_word("bvalid", 1, bvalid);
            check_word("awready", 0, awready);
            check_controls('0, '0, '0);
        end
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
        if (probe) begin
            do @(negedge clk); while (!awready);
            @(posedge clk);
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b1;
            do @(negedge clk); while (!bvalid);
            // Unmapped index leaves every output alone
            check_controls('0, '0, '0);
            @(posedge clk);
            bready <= 1'b0;
        end
    endtask

    // One read with rready low for stall+1 cycles and an optional second read pending
    task automatic read_word(input reg_index_t idx, input int stall, input bit probe);
        data_word_t expected;
        int         i;
        expected = expected_read(idx);
        @(posedge clk);
        araddr  <= make_addr(idx);
        arvalid <= 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        check_word("rvalid", 1, rvalid);
        check_word("rresp", RESP_OKAY, rresp);
        check_word("rdata", expected, rdata);
        if (probe) begin
            @(posedge clk);
            araddr  <= make_addr(4'hf);
            arvalid <= 1'b1;
        end
        for (i = 0; i <= stall; i++) begin
            @(negedge clk);
            check_word("rvalid", 1, rvalid);
            check_word("rdata", expected, rdata);
            check_word("arready", 0, arready);
        end
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
        if (probe) begin
            do @(negedge clk); while (!arready);
            @(posedge clk);
            arvalid <= 1'b0;
            rready  <= 1'b1;
            do @(negedge clk); while (!rvalid);
            check_word("rdata", 32'h0, rdata);
            @(posedge clk);
            rready <= 1'b0;
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin
        int           k;
        reg_index_t   idx;
        data_word_t   data;
        byte_strobe_t strb;
        seed              = 32'hb44a;
        errors            = 0;
        tests             = 0;
        failed_tests      = 0;
        test_start_errors = 0;
        pwm_val_model     = '0;
        ps_status_model   = '0;
        gen_status_model  = '0;
        pwm_status_model  = '0;
        rst_n             = 1'b0;
        awaddr            = '0;
        awvalid           = 1'b0;
        wdata             = '0;
        wstrb             = '0;
        wvalid            = 1'b0;
        bready            = 1'b0;
        araddr            = '0;
        arvalid           = 1'b0;
        rready            = 1'b0;
        pulsesync_status  = '0;
        gen_status        = '0;
        pwm_status        = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        begin_test();
        @(negedge clk);
        check_word("awready", 0, awready);
        check_word("wready", 0, wready);
        check_word("bvalid", 0, bvalid);
        check_word("arready", 0, arready);
        check_word("rvalid", 0, rvalid);
        check_word("rdata", 0, rdata);
        check_controls('0, '0, '0);
        end_test("reset_values");

        // Every index whether mapped or not
        begin_test();
        for (k = 0; k < 16; k++) begin
            read_word(reg_index_t'(k), 0, 1'b0);
        end
        end_test("fixed_words");

        begin_test();
        for (k = 0; k < 3; k++) begin
            ps_status_model  = $random(seed);
            gen_status_model = $random(seed);
            pwm_status_model = $random(seed);
            @(posedge clk);
            pulsesync_status <= ps_status_model;
            gen_status       <= gen_status_model;
            pwm_status       <= pwm_status_model;
            // Let the sampling register settle
            repeat (2) @(posedge clk);
            read_word(IDX_PULSESYNC_STATUS, $unsigned($random(seed)) % 3, 1'b0);
            read_word(IDX_GEN_STATUS, $unsigned($random(seed)) % 3, 1'b0);
            read_word(IDX_PWM_STATUS, $unsigned($random(seed)) % 3, 1'b0);
        end
        end_test("status_readback");

        begin_test();
        for (k = 0; k < 30; k++) begin
            data = $random(seed);
            strb = byte_strobe_t'($random(seed));
            case ($unsigned($random(seed)) % 3)
                0:       idx = IDX_PULSESYNC_CTRL;
                1:       idx = IDX_PWM_CTRL;
                default: idx = IDX_GEN_CTRL;
            endcase
            write_word(idx, data, strb, 0, 1'b0);
        end
        end_test("command_pulses");

        begin_test();
        for (k = 0; k < 20; k++) begin
            data = $random(seed);
            strb = byte_strobe_t'($random(seed));
            write_word(IDX_PWM_VAL, data, strb, $unsigned($random(seed)) % 3, 1'b0);
        end
        end_test("pwm_val_merge");

        // Long stalls with a second transaction waiting on each channel
        begin_test();
        for (k = 0; k < 10; k++) begin
            data = $random(seed);
            strb = byte_strobe_t'($random(seed));
            idx  = reg_index_t'($unsigned($random(seed)) % 4);
            write_word(idx, data, strb, $unsigned($random(seed)) % 6 + 1, 1'b1);
            idx  = reg_index_t'($unsigned($random(seed)) % 5 + 4);
            read_word(idx, $unsigned($random(seed)) % 6 + 1, 1'b1);
        end
        end_test("back_pressure");

        $display("tests run: %0d, tests failed: %0d, errors: %0d", tests, failed_tests,
                 error_total());
        if (error_total() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: pulsesync_memory_map_props.sv
`timescale 1ns/1ps

module pulsesync_memory_map_props
    import pulsesync_pkg::*;
(
    input logic       s_axi_aclk,
    input logic       s_axi_aresetn,
    input logic       s_axi_awready,
    input logic       s_axi_wready,
    input logic       s_axi_bvalid,
    input logic       s_axi_bready,
    input logic       s_axi_rvalid,
    input logic       s_axi_rready,
    input data_word_t s_axi_rdata,
    input data_word_t pulsesync_ctrl,
    input data_word_t pwm_ctrl,
    input data_word_t pwm_val,
    input data_word_t gen_ctrl
);

    // Number of assertion failures so far
    int failures = 0;

    // ------------------------------
    // Response channels
    // ------------------------------

    // Write response waits for the master
    assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
    else begin
        $error("bvalid dropped before bready");
        failures++;
    end

    // Read data frozen while stalled
    assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
    else begin
        $error("rvalid or rdata changed before rready");
        failures++;
    end

    // ------------------------------
    // Write accept
    // ------------------------------

    assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_awready == s_axi_wready)
    else begin
        $error("awready and wready differ");
        failures++;
    end

    // Single-cycle accept pulse
    assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_awready |=> !s_axi_awready)
    else begin
        $error("awready high for more than one cycle");
        failures++;
    end

    // Outputs cleared by the synchronous reset
    assert property (@(posedge s_axi_aclk)
        !s_axi_aresetn |=> (pulsesync_ctrl == '0 && pwm_ctrl == '0
                            && pwm_val == '0 && gen_ctrl == '0))
    else begin
        $error("control output not zero in reset");
        failures++;
    end

endmodule

// File: pulsesync_memory_map.sv
`timescale 1ns/1ps

module pulsesync_memory_map
    import pulsesync_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  s_axi_aclk,
    input  logic                  s_axi_aresetn,

    // AXI4-Lite write channels
    input  logic [ADDR_WIDTH-1:0] s_axi_awaddr,
    input  logic                  s_axi_awvalid,
    output logic                  s_axi_awready,
    input  data_word_t            s_axi_wdata,
    input  byte_strobe_t          s_axi_wstrb,
    input  logic                  s_axi_wvalid,
    output logic                  s_axi_wready,
    output logic [1:0]            s_axi_bresp,
    output logic                  s_axi_bvalid,
    input  logic                  s_axi_bready,

    // AXI4-Lite read channels
    input  logic [ADDR_WIDTH-1:0] s_axi_araddr,
    input  logic                  s_axi_arvalid,
    output logic                  s_axi_arready,
    output data_word_t            s_axi_rdata,
    output logic [1:0]            s_axi_rresp,
    output logic                  s_axi_rvalid,
    input  logic                  s_axi_rready,

    // Gate driver, generator and DC/DC PWM words
    input  data_word_t            pulsesync_status,
    input  data_word_t            gen_status,
    input  data_word_t            pwm_status,
    output data_word_t            pulsesync_ctrl,
    output data_word_t            pwm_ctrl,
    output data_word_t            pwm_val,
    output data_word_t            gen_ctrl
);

    reg_write_t wr_req;
    reg_index_t rd_index;
    data_word_t rd_data;

    axil_write_channel #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_write_channel (
        .s_axi_aclk   (s_axi_aclk),
        .s_axi_aresetn(s_axi_aresetn),
        .awaddr       (s_axi_awaddr),
        .awvalid      (s_axi_awvalid),
        .awready      (s_axi_awready),
        .wdata        (s_axi_wdata),
        .wstrb        (s_axi_wstrb),
        .wvalid       (s_axi_wvalid),
        .wready       (s_axi_wready),
        .bvalid       (s_axi_bvalid),
        .bresp        (s_axi_bresp),
        .bready       (s_axi_bready),
        .wr_req       (wr_req)
    );

    axil_read_channel #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_read_channel (
        .s_axi_aclk   (s_axi_aclk),
        .s_axi_aresetn(s_axi_aresetn),
        .araddr       (s_axi_araddr),
        .arvalid      (s_axi_arvalid),
        .arready      (s_axi_arready),
        .rvalid       (s_axi_rvalid),
        .rresp        (s_axi_rresp),
        .rdata        (s_axi_rdata),
        .rready       (s_axi_rready),
        .rd_data      (rd_data),
        .rd_index     (rd_index)
    );

    // Write and read paths meet only here
    pulsesync_reg_file u_reg_file (
        .s_axi_aclk      (s_axi_aclk),
        .s_axi_aresetn   (s_axi_aresetn),
        .wr_req          (wr_req),
        .rd_index        (rd_index),
        .pulsesync_status(pulsesync_status),
        .gen_status      (gen_status),
        .pwm_status      (pwm_status),
        .rd_data         (rd_data),
        .pulsesync_ctrl  (pulsesync_ctrl),
        .pwm_ctrl        (pwm_ctrl),
        .pwm_val         (pwm_val),
        .gen_ctrl        (gen_ctrl)
    );

endmodule

// File: pulsesync_reg_file.sv
`timescale 1ns/1ps

module pulsesync_reg_file
    import pulsesync_pkg::*;
(
    input  logic       s_axi_aclk,
    input  logic       s_axi_aresetn,
    input  reg_write_t wr_req,
    input  reg_index_t rd_index,
    input  data_word_t pulsesync_status,
    input  data_word_t gen_status,
    input  data_word_t pwm_status,
    output data_word_t rd_data,
    output data_word_t pulsesync_ctrl,
    output data_word_t pwm_ctrl,
    output data_word_t pwm_val,
    output data_word_t gen_ctrl
);

    // Sampled status inputs
    data_word_t pulsesync_status_q;
    data_word_t gen_status_q;
    data_word_t pwm_status_q;

    // Replace the strobed bytes of a word, keep the rest
    function automatic data_word_t merge_bytes(data_word_t base, data_word_t data,
                                               byte_strobe_t strobe);
        data_word_t result;
        result = base;
        for (int i = 0; i < $bits(byte_strobe_t); i++) begin
            if (strobe[i]) begin
                result[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return result;
    endfunction

    // ------------------------------
    // Control registers
    // ------------------------------

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            pulsesync_ctrl <= '0;
            pwm_ctrl       <= '0;
            gen_ctrl       <= '0;
            pwm_val        <= '0;
        end else begin
            // Command words are zero unless written in this cycle
            pulsesync_ctrl <= '0;
            pwm_ctrl       <= '0;
            gen_ctrl       <= '0;
            if (wr_req.valid) begin
                case (wr_req.index)
                    IDX_PULSESYNC_CTRL:
                        pulsesync_ctrl <= merge_bytes('0, wr_req.data, wr_req.strobe);
                    IDX_PWM_CTRL:
                        pwm_ctrl <= merge_bytes('0, wr_req.data, wr_req.strobe);
                    IDX_GEN_CTRL:
                        gen_ctrl <= merge_bytes('0, wr_req.data, wr_req.strobe);
                    // PWM value persists, unstrobed bytes kept
                    IDX_PWM_VAL:
                        pwm_val <= merge_bytes(pwm_val, wr_req.data, wr_req.strobe);
                    default: ;
                endcase
            end
        end
    end

    // ------------------------------
    // Status sampling
    // ------------------------------

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            pulsesync_status_q <= '0;
            gen_status_q       <= '0;
            pwm_status_q       <= '0;
        end else begin
            pulsesync_status_q <= pulsesync_status;
            gen_status_q       <= gen_status;
            pwm_status_q       <= pwm_status;
        end
    end

    // Read mux, control words are write only and read as zero
    always_comb begin
        case (rd_index)
            IDX_PULSESYNC_STATUS: rd_data = pulsesync_status_q;
            IDX_GEN_STATUS:       rd_data = gen_status_q;
            IDX_PWM_STATUS:       rd_data = pwm_status_q;
            IDX_VERSION:          rd_data = VERSION_WORD;
            IDX_VALIDATION:       rd_data = VALIDATION_WORD;
            default:              rd_data = '0;
        endcase
    end

endmodule

// File: axil_read_channel.sv
`timescale 1ns/1ps

module axil_read_channel
    import pulsesync_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  s_axi_aclk,
    input  logic                  s_axi_aresetn,
    input  logic [ADDR_WIDTH-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic                  rvalid,
    output logic [1:0]            rresp,
    output data_word_t            rdata,
    input  logic                  rready,
    input  data_word_t            rd_data,
    output reg_index_t            rd_index
);

    rd_state_t  rd_state;

    // ------------------------------
    // Read FSM
    // ------------------------------

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rd_state <= RD_IDLE;
            rdata    <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (arvalid) begin
                        rd_state <= RD_ACCEPT;
                    end
                end
                // Mux output settles on the latched index in this cycle
                RD_ACCEPT: begin
                    rdata    <= rd_data;
                    rd_state <= RD_DATA;
                end
                // rdata held stable while the master stalls
                RD_DATA: begin
                    if (rready) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // Word index latched when the address is accepted
    always_ff @(posedge s_axi_aclk) begin
        if (rd_state == RD_IDLE && arvalid) begin
            rd_index <= araddr[ADDR_LSB +: $bits(reg_index_t)];
        end
    end

    // Handshake outputs follow the state directly
    assign arready = (rd_state == RD_ACCEPT);
    assign rvalid  = (rd_state == RD_DATA);
    assign rresp   = RESP_OKAY;

endmodule

// File: axil_write_channel.sv
`timescale 1ns/1ps

module axil_write_channel
    import pulsesync_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  s_axi_aclk,
    input  logic                  s_axi_aresetn,
    input  logic [ADDR_WIDTH-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  data_word_t            wdata,
    input  byte_strobe_t          wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic                  bvalid,
    output logic [1:0]            bresp,
    input  logic                  bready,
    output reg_write_t            wr_req
);

    wr_state_t    wr_state;

    // Latched write payload
    reg_index_t   wr_index;
    data_word_t   wr_data;
    byte_strobe_t wr_strobe;

    // ------------------------------
    // Write FSM
    // ------------------------------

    // Address and data are only taken together, one write at a time
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (awvalid && wvalid) begin
                        wr_state <= WR_ACCEPT;
                    end
                end
                // Register file updates at the end of this cycle
                WR_ACCEPT: wr_state <= WR_RESP;
                // Response held until the master takes it
                WR_RESP: begin
                    if (bready) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // Capture word index, data and strobes on the accepting edge
    always_ff @(posedge s_axi_aclk) begin
        if (wr_state == WR_IDLE && awvalid && wvalid) begin
            wr_index  <= awaddr[ADDR_LSB +: $bits(reg_index_t)];
            wr_data   <= wdata;
            wr_strobe <= wstrb;
        end
    end

    // ------------------------------
    // Handshake outputs
    // ------------------------------

    // Both readies pulse together for the single accept cycle
    assign awready = (wr_state == WR_ACCEPT);
    assign wready  = (wr_state == WR_ACCEPT);
    assign bvalid  = (wr_state == WR_RESP);
    assign bresp   = RESP_OKAY;

    // One-cycle write strobe into the register file
    assign wr_req = '{
        valid:  (wr_state == WR_ACCEPT),
        index:  wr_index,
        data:   wr_data,
        strobe: wr_strobe
    };

endmodule

// File: pulsesync_pkg.sv
package pulsesync_pkg;

    // ------------------------------
    // Word types
    // ------------------------------

    // One register word on the AXI data bus
    typedef logic [31:0] data_word_t;

    // One enable bit per byte lane of data_word_t
    typedef logic [3:0] byte_strobe_t;

    // Word index taken from address bits 5:2
    typedef logic [3:0] reg_index_t;

    // ------------------------------
    // Register map
    // ------------------------------

    // Control words, written by the host
    localparam reg_index_t IDX_PULSESYNC_CTRL   = 4'd0;
    localparam reg_index_t IDX_PWM_CTRL         = 4'd1;
    localparam reg_index_t IDX_PWM_VAL          = 4'd2;
    localparam reg_index_t IDX_GEN_CTRL         = 4'd3;

    // Status and identification words, read only
    localparam reg_index_t IDX_PULSESYNC_STATUS = 4'd4;
    localparam reg_index_t IDX_GEN_STATUS       = 4'd5;
    localparam reg_index_t IDX_PWM_STATUS       = 4'd6;
    localparam reg_index_t IDX_VERSION          = 4'd7;
    localparam reg_index_t IDX_VALIDATION       = 4'd8;

    // Fixed readback values
    localparam data_word_t VERSION_WORD    = 32'h1234_5678;
    localparam data_word_t VALIDATION_WORD = 32'hDEAD_BEEF;

    // Byte offset bits below the word index
    localparam int ADDR_LSB = 2;

    // AXI response code, only OKAY is ever returned
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Write request from the write channel to the register file
    typedef struct packed {
        logic         valid;
        reg_index_t   index;
        data_word_t   data;
        byte_strobe_t strobe;
    } reg_write_t;

    // Channel FSM states
    typedef enum logic [1:0] {WR_IDLE, WR_ACCEPT, WR_RESP} wr_state_t;
    typedef enum logic [1:0] {RD_IDLE, RD_ACCEPT, RD_DATA} rd_state_t;

endpackage
